/* alu.sv */
// Eight-operation ALU
// Logic, add, subtract, shift left and set-less-than
// Zero flag on the result

`timescale 1ns/1ps

module alu import isa_pkg::*, alu_pkg::*; (
	input  alu_ctrl_t ctrl,
	input  word_t     a,
	input  word_t     b,
	input  shamt_t    shamt,
	output word_t     result,
	output logic      zero
);

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed   = ($signed(a) < $signed(b));
	assign lt_unsigned = (a < b);

	always_comb begin
		case (ctrl)
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			// Both adds wrap on overflow
			ALU_ADD:  result = a + b;
			ALU_ADDU: result = a + b;
			ALU_SLT:  result = word_t'(lt_signed);
			ALU_SLL:  result = b << shamt;
			ALU_SUB:  result = a - b;
			ALU_SLTU: result = word_t'(lt_unsigned);
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

/* alu_pkg.sv */
// ALU operation encoding
// Three-bit control code typedef and the eight operation codes

package alu_pkg;

	typedef logic [2:0] alu_ctrl_t;

	localparam alu_ctrl_t ALU_AND  = 3'd0;
	localparam alu_ctrl_t ALU_OR   = 3'd1;
	// Signed add, no overflow trap
	localparam alu_ctrl_t ALU_ADD  = 3'd2;
	localparam alu_ctrl_t ALU_SLT  = 3'd3;
	// Unsigned add, also used for load and store addresses
	localparam alu_ctrl_t ALU_ADDU = 3'd4;
	localparam alu_ctrl_t ALU_SLL  = 3'd5;
	// Subtract, also used for branch compares
	localparam alu_ctrl_t ALU_SUB  = 3'd6;
	localparam alu_ctrl_t ALU_SLTU = 3'd7;

endpackage

/* control.sv */
// Main decoder of the CPU
// One-hot instruction flags from opcode and function code
// Datapath controls, ALU operation code and branch decision

`timescale 1ns/1ps

module control import isa_pkg::*, alu_pkg::*; (
	input  opcode_t   op,
	input  funct_t    fun,
	input  logic      equal,
	input  logic      sign,
	output logic      npc_sel,
	output logic      reg_wr,
	output logic      reg_dst,
	output logic      ext_op,
	output logic      alu_src,
	output logic      mem_wr,
	output logic      mem_to_reg,
	output alu_ctrl_t alu_ctrl
);

	logic r_type;
	logic is_add, is_addu, is_sub, is_subu, is_and, is_or;
	logic is_sll, is_slt, is_sltu;
	logic is_addi, is_lw, is_sw, is_beq, is_bne, is_bgtz;
	logic r_valid;
	logic branch;

	assign r_type = (op == OP_RTYPE);

	// R-type flags need a known function code
	assign is_add  = r_type && (fun == FN_ADD);
	assign is_addu = r_type && (fun == FN_ADDU);
	assign is_sub  = r_type && (fun == FN_SUB);
	assign is_subu = r_type && (fun == FN_SUBU);
	assign is_and  = r_type && (fun == FN_AND);
	assign is_or   = r_type && (fun == FN_OR);
	assign is_sll  = r_type && (fun == FN_SLL);
	assign is_slt  = r_type && (fun == FN_SLT);
	assign is_sltu = r_type && (fun == FN_SLTU);

	assign is_addi = (op == OP_ADDI);
	assign is_lw   = (op == OP_LW);
	assign is_sw   = (op == OP_SW);
	assign is_beq  = (op == OP_BEQ);
	assign is_bne  = (op == OP_BNE);
	assign is_bgtz = (op == OP_BGTZ);

	assign r_valid = is_add | is_addu | is_sub | is_subu | is_and | is_or |
	                 is_sll | is_slt | is_sltu;
	assign branch  = is_beq | is_bne | is_bgtz;

	// Branches take rt as the second ALU operand as R-type does
	assign reg_dst    = r_type | branch;
	assign alu_src    = ~reg_dst;
	// Unknown encodings fall out with no write
	assign reg_wr     = r_valid | is_addi | is_lw;
	assign ext_op     = is_addi | is_lw | is_sw;
	assign mem_wr     = is_sw;
	assign mem_to_reg = is_lw;

	// and takes the default code
	always_comb begin
		alu_ctrl = ALU_AND;
		if (is_or) begin
			alu_ctrl = ALU_OR;
		end else if (is_add || is_addi) begin
			alu_ctrl = ALU_ADD;
		end else if (is_slt) begin
			alu_ctrl = ALU_SLT;
		end else if (is_addu || is_lw || is_sw) begin
			alu_ctrl = ALU_ADDU;
		end else if (is_sll) begin
			alu_ctrl = ALU_SLL;
		end else if (is_sub || is_subu || branch) begin
			alu_ctrl = ALU_SUB;
		end else if (is_sltu) begin
			alu_ctrl = ALU_SLTU;
		end
	end

	// bgtz needs rs - rt nonzero with the sign bit clear
	assign npc_sel = (is_beq & equal) | (is_bne & ~equal) | (is_bgtz & ~equal & ~sign);

endmodule

/* cpu.sv */
// Single-cycle CPU top level
// Fetch, decode, register file, ALU and data memory
// Immediate extender, operand and writeback selects
// Commit outputs for register and memory writes

`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu import isa_pkg::*, alu_pkg::*; (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            load_en,
	input  logic [$clog2(`IMEM_DEPTH)-1:0] load_addr,
	input  word_t                           load_data,
	output word_t                           pc,
	output logic                            reg_we,
	output reg_addr_t                       reg_waddr,
	output word_t                           reg_wdata,
	output logic                            mem_we,
	output word_t                           mem_addr,
	output word_t                           mem_wdata
);

	word_t     inst;
	reg_addr_t rs, rt, rd;
	shamt_t    shamt;
	imm16_t    imm16;

	logic      npc_sel, reg_wr, reg_dst, ext_op, alu_src, mem_wr, mem_to_reg;
	alu_ctrl_t alu_ctrl;
	logic      equal, sign;
	logic      commit_en;

	word_t     bus_a, bus_b, bus_w;
	word_t     imm32, alu_b, alu_out, dmem_out;

	fetch_inst u_fetch (
		.clk(clk), .rst_n(rst_n), .hold(load_en),
		.load_addr(load_addr), .load_data(load_data),
		.npc_sel(npc_sel), .imm16(imm16), .pc(pc), .inst(inst)
	);

	// Instruction fields
	assign rs    = inst[25:21];
	assign rt    = inst[20:16];
	assign rd    = inst[15:11];
	assign shamt = inst[10:6];
	assign imm16 = inst[15:0];

	control u_control (
		.op(inst[31:26]), .fun(inst[5:0]), .equal(equal), .sign(sign),
		.npc_sel(npc_sel), .reg_wr(reg_wr), .reg_dst(reg_dst), .ext_op(ext_op),
		.alu_src(alu_src), .mem_wr(mem_wr), .mem_to_reg(mem_to_reg), .alu_ctrl(alu_ctrl)
	);

	// No architectural writes in reset or while a program loads
	assign commit_en = rst_n & ~load_en;
	assign reg_we    = reg_wr & commit_en;
	assign mem_we    = mem_wr & commit_en;

	assign reg_waddr = reg_dst ? rd : rt;
	assign bus_w     = mem_to_reg ? dmem_out : alu_out;
	assign reg_wdata = bus_w;

	registers u_regs (
		.clk(clk), .rst_n(rst_n), .we(reg_we), .rw(reg_waddr),
		.ra(rs), .rb(rt), .bus_w(bus_w), .bus_a(bus_a), .bus_b(bus_b)
	);

	assign imm32 = ext_op ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};
	assign alu_b = alu_src ? imm32 : bus_b;

	alu u_alu (
		.ctrl(alu_ctrl), .a(bus_a), .b(alu_b), .shamt(shamt),
		.result(alu_out), .zero(equal)
	);
	assign sign = alu_out[31];

	assign mem_addr  = alu_out;
	assign mem_wdata = bus_b;

	d_mem u_dmem (
		.clk(clk), .we(mem_we), .adr(alu_out), .data_in(bus_b), .data_out(dmem_out)
	);

endmodule

/* cpu_params.svh */
// Global sizing for the single-cycle CPU
// Machine word width
// Instruction and data memory depths in words
// Program counter value after reset

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Machine word width in bits
`define DATA_W 32

// Instruction memory words, indexed by PC bits 7:2
`define IMEM_DEPTH 64

// Data memory words, indexed by address bits 7:2
`define DMEM_DEPTH 64

// First fetch address
`define RESET_PC 0

`endif

/* d_mem.sv */
// Data memory
// Word-addressed array, combinational read, clocked write
// Contents start at zero

`timescale 1ns/1ps
`include "cpu_params.svh"

module d_mem import isa_pkg::*; (
	input  logic  clk,
	input  logic  we,
	input  word_t adr,
	input  word_t data_in,
	output word_t data_out
);

	localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

	word_t mem [`DMEM_DEPTH];

	initial begin
		for (int i = 0; i < `DMEM_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Byte address bits 1:0 are ignored
	always_ff @(posedge clk) begin
		if (we) begin
			mem[adr[DMEM_AW+1:2]] <= data_in;
		end
	end

	assign data_out = mem[adr[DMEM_AW+1:2]];

endmodule

/* fetch_inst.sv */
// Instruction fetch stage
// Program counter register with sequential and branch next-PC
// Instruction memory with a word-wide load port

`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_inst import isa_pkg::*; (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            hold,
	input  logic [$clog2(`IMEM_DEPTH)-1:0] load_addr,
	input  word_t                           load_data,
	input  logic                            npc_sel,
	input  imm16_t                          imm16,
	output word_t                           pc,
	output word_t                           inst
);

	localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

	word_t imem [`IMEM_DEPTH];
	word_t pc_plus4;
	word_t branch_off;
	word_t pc_next;

	// Word offset of the branch, sign extended and scaled by 4
	assign branch_off = {{14{imm16[15]}}, imm16, 2'b00};
	assign pc_plus4   = pc + 32'd4;
	assign pc_next    = npc_sel ? (pc_plus4 + branch_off) : pc_plus4;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= word_t'(`RESET_PC);
		end else if (!hold) begin
			pc <= pc_next;
		end
	end

	// Program load writes one word per cycle
	always_ff @(posedge clk) begin
		if (hold) begin
			imem[load_addr] <= load_data;
		end
	end

	assign inst = imem[pc[IMEM_AW+1:2]];

endmodule

/* files.f */
+incdir+.
isa_pkg.sv
alu_pkg.sv
fetch_inst.sv
control.sv
registers.sv
alu.sv
d_mem.sv
cpu.sv
tb_cpu.sv

/* isa_pkg.sv */
// Instruction set definitions for the MIPS-style subset
// Field typedefs for words, register indices, opcodes and immediates
// Opcode and function code constants

`include "cpu_params.svh"

package isa_pkg;

	typedef logic [`DATA_W-1:0] word_t;
	typedef logic [4:0]         reg_addr_t;
	typedef logic [5:0]         opcode_t;
	typedef logic [5:0]         funct_t;
	typedef logic [15:0]        imm16_t;
	typedef logic [4:0]         shamt_t;

	// Primary opcodes
	localparam opcode_t OP_RTYPE = 6'd0;
	localparam opcode_t OP_BEQ   = 6'd4;
	localparam opcode_t OP_BNE   = 6'd5;
	localparam opcode_t OP_BGTZ  = 6'd7;
	localparam opcode_t OP_ADDI  = 6'd8;
	localparam opcode_t OP_LW    = 6'd35;
	localparam opcode_t OP_SW    = 6'd43;

	// R-type function codes
	localparam funct_t FN_SLL  = 6'd0;
	localparam funct_t FN_ADD  = 6'd32;
	localparam funct_t FN_ADDU = 6'd33;
	localparam funct_t FN_SUB  = 6'd34;
	localparam funct_t FN_SUBU = 6'd35;
	localparam funct_t FN_AND  = 6'd36;
	localparam funct_t FN_OR   = 6'd37;
	localparam funct_t FN_SLT  = 6'd42;
	localparam funct_t FN_SLTU = 6'd43;

endpackage

/* registers.sv */
// General purpose register file
// 32 words, two combinational read ports, one clocked write port
// Register 0 always reads zero

`timescale 1ns/1ps

module registers import isa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      we,
	input  reg_addr_t rw,
	input  reg_addr_t ra,
	input  reg_addr_t rb,
	input  word_t     bus_w,
	output word_t     bus_a,
	output word_t     bus_b
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rw != 5'd0)) begin
			regs[rw] <= bus_w;
		end
	end

	// Register 0 is never written so it stays at its reset value
	assign bus_a = regs[ra];
	assign bus_b = regs[rb];

endmodule

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module tb_cpu -o Vtb_cpu
./obj_dir/Vtb_cpu > sim.log
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation reported failures"
	exit 1
fi
echo "Simulation finished without failures"

/* tb_ref_model.svh */
// Testbench helpers for the single-cycle CPU
// Instruction encoders for R-type and I-type words
// Architectural reference model with program copy, PC, registers and data memory
// Step and commit functions for the expected result of one instruction

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

word_t m_prog [`IMEM_DEPTH];
word_t m_pc;
word_t m_regs [32];
word_t m_mem [`DMEM_DEPTH];

function automatic word_t enc_r(input funct_t fn, input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input shamt_t sa);
	return {OP_RTYPE, rs, rt, rd, sa, fn};
endfunction

function automatic word_t enc_i(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
		input imm16_t imm);
	return {op, rs, rt, imm};
endfunction

function automatic void model_reset();
	m_pc = word_t'(`RESET_PC);
	for (int i = 0; i < 32; i++) begin
		m_regs[i] = '0;
	end
	for (int i = 0; i < `DMEM_DEPTH; i++) begin
		m_mem[i] = '0;
	end
endfunction

// Expected commit of the instruction at m_pc, model state untouched
function automatic void ref_step(output logic e_reg_we, output reg_addr_t e_waddr,
		output word_t e_wdata, output logic e_mem_we, output word_t e_maddr,
		output word_t e_mdata, output word_t e_npc);
	word_t ins;
	word_t a;
	word_t b;
	word_t simm;
	word_t diff;
	word_t addr;
	logic  taken;

	ins      = m_prog[m_pc[7:2]];
	a        = m_regs[ins[25:21]];
	b        = m_regs[ins[20:16]];
	simm     = {{16{ins[15]}}, ins[15:0]};
	diff     = a - b;
	addr     = a + simm;
	taken    = 1'b0;
	e_reg_we = 1'b0;
	e_waddr  = ins[20:16];
	e_wdata  = '0;
	e_mem_we = 1'b0;
	e_maddr  = addr;
	e_mdata  = b;

	case (ins[31:26])
		OP_RTYPE: begin
			e_reg_we = 1'b1;
			e_waddr  = ins[15:11];
			case (ins[5:0])
				FN_ADD, FN_ADDU: e_wdata = a + b;
				FN_SUB, FN_SUBU: e_wdata = diff;
				FN_AND:  e_wdata = a & b;
				FN_OR:   e_wdata = a | b;
				FN_SLL:  e_wdata = b << ins[10:6];
				FN_SLT:  e_wdata = {31'b0, $signed(a) < $signed(b)};
				FN_SLTU: e_wdata = {31'b0, a < b};
				default: e_reg_we = 1'b0;
			endcase
		end
		OP_ADDI: begin
			e_reg_we = 1'b1;
			e_wdata  = addr;
		end
		OP_LW: begin
			e_reg_we = 1'b1;
			e_wdata  = m_mem[addr[7:2]];
		end
		OP_SW:   e_mem_we = 1'b1;
		OP_BEQ:  taken = (diff == '0);
		OP_BNE:  taken = (diff != '0);
		// Nonzero difference with the sign bit clear
		OP_BGTZ: taken = (diff != '0) && !diff[31];
		default: ;
	endcase

	e_npc = m_pc + 32'd4 + (taken ? {simm[29:0], 2'b00} : 32'd0);
endfunction

function automatic void ref_commit(input logic e_reg_we, input reg_addr_t e_waddr,
		input word_t e_wdata, input logic e_mem_we, input word_t e_maddr,
		input word_t e_mdata, input word_t e_npc);
	if (e_reg_we && (e_waddr != 5'd0)) begin
		m_regs[e_waddr] = e_wdata;
	end
	if (e_mem_we) begin
		m_mem[e_maddr[7:2]] = e_mdata;
	end
	m_pc = e_npc;
endfunction

`endif

/* tb_cpu.sv */
// Testbench for the single-cycle CPU
// Clock, reset and program load through the instruction memory port
// Directed and LCG-generated program checked against a reference model
// Commit comparison, error count and timeout

`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu import isa_pkg::*; ();

	localparam int RESET_CYCLES = 4;
	localparam int EXEC_LIMIT   = 120;
	localparam int TAIL_CYCLES  = 4;
	// Twice reset, load and execution together
	localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + `IMEM_DEPTH + EXEC_LIMIT);
	localparam int RAND_START   = 37;
	localparam int RAND_COUNT   = 20;
	localparam int HALT_IDX     = RAND_START + RAND_COUNT;
	localparam word_t HALT_PC   = 32'(HALT_IDX * 4);

	logic      clk;
	logic      rst_n;
	logic      load_en;
	logic [5:0] load_addr;
	word_t     load_data;
	word_t     pc;
	logic      reg_we;
	reg_addr_t reg_waddr;
	word_t     reg_wdata;
	logic      mem_we;
	word_t     mem_addr;
	word_t     mem_wdata;

	int          errors;
	int          checks;
	int          cycle_count;
	logic [31:0] lcg_state;

	`include "tb_ref_model.svh"

	cpu dut (
		.clk(clk), .rst_n(rst_n), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .pc(pc), .reg_we(reg_we), .reg_waddr(reg_waddr),
		.reg_wdata(reg_wdata), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Random R-type or addi word with addi for the upper kinds
	function automatic word_t random_inst(input logic [31:0] r);
		word_t w;

		case (r[31:28])
			4'd0:    w = enc_r(FN_ADD, r[27:23], r[22:18], r[17:13], 5'd0);
			4'd1:    w = enc_r(FN_ADDU, r[27:23], r[22:18], r[17:13], 5'd0);
			4'd2:    w = enc_r(FN_SUB, r[27:23], r[22:18], r[17:13], 5'd0);
			4'd3:    w = enc_r(FN_SUBU, r[27:23], r[22:18], r[17:13], 5'd0);
			4'd4:    w = enc_r(FN_AND, r[27:23], r[22:18], r[17:13], 5'd0);
			4'd5:    w = enc_r(FN_OR, r[27:23], r[22:18], r[17:13], 5'd0);
			4'd6:    w = enc_r(FN_SLL, 5'd0, r[22:18], r[17:13], r[12:8]);
			4'd7:    w = enc_r(FN_SLT, r[27:23], r[22:18], r[17:13], 5'd0);
			4'd8:    w = enc_r(FN_SLTU, r[27:23], r[22:18], r[17:13], 5'd0);
			default: w = enc_i(OP_ADDI, r[27:23], r[22:18], r[15:0]);
		endcase
		return w;
	endfunction

	task automatic build_program();
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			m_prog[i] = '0;
		end
		// Arithmetic and logic including wrap-around
		m_prog[0]  = enc_i(OP_ADDI, 5'd0, 5'd1, 16'd5);
		m_prog[1]  = enc_i(OP_ADDI, 5'd0, 5'd2, 16'hfffd);
		m_prog[2]  = enc_i(OP_ADDI, 5'd0, 5'd3, 16'h7fff);
		m_prog[3]  = enc_r(FN_ADD, 5'd1, 5'd2, 5'd4, 5'd0);
		m_prog[4]  = enc_r(FN_ADDU, 5'd3, 5'd3, 5'd5, 5'd0);
		m_prog[5]  = enc_r(FN_SUB, 5'd2, 5'd1, 5'd6, 5'd0);
		m_prog[6]  = enc_r(FN_SUBU, 5'd1, 5'd2, 5'd7, 5'd0);
		m_prog[7]  = enc_r(FN_AND, 5'd1, 5'd2, 5'd8, 5'd0);
		m_prog[8]  = enc_r(FN_OR, 5'd1, 5'd2, 5'd9, 5'd0);
		m_prog[9]  = enc_r(FN_SLL, 5'd0, 5'd3, 5'd10, 5'd17);
		m_prog[10] = enc_r(FN_SLL, 5'd0, 5'd3, 5'd12, 5'd16);
		m_prog[11] = enc_r(FN_ADD, 5'd12, 5'd12, 5'd13, 5'd0);
		m_prog[12] = enc_r(FN_SLT, 5'd2, 5'd1, 5'd14, 5'd0);
		m_prog[13] = enc_r(FN_SLTU, 5'd2, 5'd1, 5'd15, 5'd0);
		m_prog[14] = enc_r(FN_SLT, 5'd1, 5'd2, 5'd16, 5'd0);
		// Stores followed by loads of stored and untouched words
		m_prog[15] = enc_i(OP_SW, 5'd0, 5'd1, 16'd8);
		m_prog[16] = enc_i(OP_SW, 5'd0, 5'd2, 16'd12);
		m_prog[17] = enc_i(OP_LW, 5'd0, 5'd17, 16'd8);
		m_prog[18] = enc_i(OP_LW, 5'd0, 5'd18, 16'd12);
		m_prog[19] = enc_i(OP_LW, 5'd1, 5'd19, 16'd11);
		// Branches taken and not taken
		m_prog[20] = enc_i(OP_BEQ, 5'd1, 5'd1, 16'd1);
		m_prog[21] = enc_i(OP_ADDI, 5'd0, 5'd20, 16'd99);
		m_prog[22] = enc_i(OP_BEQ, 5'd1, 5'd2, 16'd1);
		m_prog[23] = enc_i(OP_BNE, 5'd1, 5'd2, 16'd1);
		m_prog[24] = enc_i(OP_ADDI, 5'd0, 5'd20, 16'd98);
		m_prog[25] = enc_i(OP_BNE, 5'd1, 5'd1, 16'd1);
		m_prog[26] = enc_i(OP_BGTZ, 5'd2, 5'd0, 16'd1);
		m_prog[27] = enc_i(OP_BGTZ, 5'd0, 5'd0, 16'd1);
		m_prog[28] = enc_i(OP_BGTZ, 5'd1, 5'd0, 16'd1);
		m_prog[29] = enc_i(OP_ADDI, 5'd0, 5'd20, 16'd97);
		// Backward loop of four passes
		m_prog[30] = enc_i(OP_ADDI, 5'd0, 5'd21, 16'd4);
		m_prog[31] = enc_i(OP_ADDI, 5'd22, 5'd22, 16'd1);
		m_prog[32] = enc_i(OP_ADDI, 5'd21, 5'd21, 16'hffff);
		m_prog[33] = enc_i(OP_BNE, 5'd21, 5'd0, 16'hfffd);
		// Register 0 write followed by an unknown opcode
		m_prog[34] = enc_i(OP_ADDI, 5'd0, 5'd0, 16'd7);
		m_prog[35] = enc_r(FN_ADD, 5'd0, 5'd1, 5'd23, 5'd0);
		m_prog[36] = enc_i(6'd63, 5'd1, 5'd2, 16'h1234);
		for (int i = 0; i < RAND_COUNT; i++) begin
			m_prog[RAND_START + i] = random_inst(lcg_next());
		end
		// Halt as a branch to itself
		m_prog[HALT_IDX] = enc_i(OP_BEQ, 5'd0, 5'd0, 16'hffff);
	endtask

	initial begin : stimulus
		errors    = 0;
		checks    = 0;
		lcg_state = 32'hbbbb_384b;
		rst_n     = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		build_program();
		model_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n   = 1'b1;
		load_en = 1'b1;
		// A store sits at address 0 for one load cycle before the program
		load_addr = '0;
		load_data = enc_i(OP_SW, 5'd0, 5'd0, 16'd0);
		@(posedge clk);
		#1;
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			load_addr = 6'(i);
			load_data = m_prog[i];
			@(posedge clk);
			#1;
		end
		load_en = 1'b0;
		while (m_pc != HALT_PC) begin
			@(posedge clk);
		end
		repeat (TAIL_CYCLES) @(posedge clk);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Commit outputs sampled 1 ns before the next rising edge
	always @(posedge clk) begin : compare
		logic      e_reg_we;
		logic      e_mem_we;
		reg_addr_t e_waddr;
		word_t     e_wdata;
		word_t     e_maddr;
		word_t     e_mdata;
		word_t     e_npc;

		#9;
		if (!rst_n || load_en) begin
			check_value("pc", pc, word_t'(`RESET_PC));
			check_value("reg_we", word_t'(reg_we), '0);
			check_value("mem_we", word_t'(mem_we), '0);
		end else begin
			ref_step(e_reg_we, e_waddr, e_wdata, e_mem_we, e_maddr, e_mdata, e_npc);
			check_value("pc", pc, m_pc);
			check_value("reg_we", word_t'(reg_we), word_t'(e_reg_we));
			if (e_reg_we) begin
				check_value("reg_waddr", word_t'(reg_waddr), word_t'(e_waddr));
				check_value("reg_wdata", reg_wdata, e_wdata);
			end
			check_value("mem_we", word_t'(mem_we), word_t'(e_mem_we));
			if (e_mem_we) begin
				check_value("mem_addr", mem_addr, e_maddr);
				check_value("mem_wdata", mem_wdata, e_mdata);
			end
			ref_commit(e_reg_we, e_waddr, e_wdata, e_mem_we, e_maddr, e_mdata, e_npc);
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the program did not reach its halt loop within %0d cycles",
			MAX_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule
